//--- Makefile
# Verilator build and run for the DFU control endpoint testbench

VERILATOR ?= verilator
TOP       ?= tb_usb_dfu_ctrl
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all run build lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/ctrl_xfer_fsm.sv
`timescale 1ns/1ps

module ctrl_xfer_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     setup_start,
  input  logic                     pkt_end,
  input  usb_ctrl_pkg::setup_pkt_u setup,
  input  logic                     in_ep_grant,
  input  logic                     in_ep_data_free,
  input  logic                     in_ep_acked,
  input  logic                     out_ep_acked,
  output logic                     in_ep_req,
  output logic                     in_ep_data_put,
  output logic                     in_ep_data_done,
  output logic                     in_ep_stall,
  output logic                     setup_end,
  output logic                     status_end,
  resp_if.stage                    resp
);
  import usb_ctrl_pkg::*;

  ctrl_stage_e stage_q;
  ctrl_stage_e stage_d;
  logic        has_data;
  logic        dir_in;
  logic        all_sent;
  logic        step;     // one byte accepted by the endpoint
  logic        zlp;
  logic        done_q;

  assign has_data = |setup.fields.w_length;
  assign dir_in   = setup.fields.bm_request_type[7];
  assign all_sent = resp.byte_index >= resp.length;

  assign in_ep_req       = (stage_q == stage_data_in) && !all_sent;
  assign in_ep_data_put  = in_ep_req && in_ep_data_free;
  assign step            = in_ep_data_put && in_ep_grant;
  assign in_ep_data_done = done_q || zlp;

  //////////////////////////////////////////////////
  // stage machine
  //////////////////////////////////////////////////

  always_comb begin
    stage_d    = stage_q;
    setup_end  = 1'b0;
    status_end = 1'b0;
    zlp        = 1'b0;
    case (stage_q)
      stage_idle: if (setup_start) stage_d = stage_setup;
      stage_setup: begin
        if (pkt_end) begin
          setup_end = 1'b1;
          if (!has_data) begin
            stage_d = stage_status_in;
            zlp     = 1'b1; // no data stage, status goes out right away
          end else if (dir_in) begin
            stage_d = stage_data_in;
          end else begin
            stage_d = stage_data_out;
          end
        end
      end
      stage_data_in: begin
        if (in_ep_stall) begin
          stage_d    = stage_idle;
          status_end = 1'b1;
        end else if (in_ep_acked && all_sent) begin
          stage_d = stage_status_out;
        end
      end
      stage_data_out: begin
        if (out_ep_acked) begin // payload dropped
          stage_d = stage_status_in;
          zlp     = 1'b1;
        end
      end
      stage_status_in, stage_status_out: begin
        if ((stage_q == stage_status_in) ? in_ep_acked : out_ep_acked) begin
          stage_d    = stage_idle;
          status_end = 1'b1;
        end
      end
      default: stage_d = stage_idle;
    endcase
    if (setup_start) stage_d = stage_setup; // a new setup aborts the transfer
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_q         <= stage_idle;
      resp.byte_index <= 8'd0;
      done_q          <= 1'b0;
      in_ep_stall     <= 1'b0;
    end else begin
      stage_q     <= stage_d;
      done_q      <= step && (resp.byte_index + 8'd1 == resp.length);
      in_ep_stall <= resp.stall_req;
      if (stage_q == stage_idle || stage_q == stage_setup) begin
        resp.byte_index <= 8'd0;
      end else if (step) begin
        resp.byte_index <= resp.byte_index + 8'd1;
      end
    end
  end

  a_put_in_data: assert property (@(posedge clk) disable iff (reset)
    in_ep_data_put |-> stage_q == stage_data_in);

  // decoder length bounds the count for the whole transfer
  a_index_bound: assert property (@(posedge clk) disable iff (reset)
    resp.byte_index <= resp.length);

endmodule

//--- src/dfu_pkg.sv
package dfu_pkg;

  // bState values, only the ones this device can reach
  typedef enum logic [7:0] {
    app_idle        = 8'h00,
    dfu_idle        = 8'h02,
    dfu_upload_idle = 8'h09,
    dfu_error       = 8'h0a
  } dfu_state_e;

  localparam logic [7:0] dfu_status_ok = 8'h00;

  // class requests on the DFU interface
  localparam logic [7:0] dfu_req_upload    = 8'h02;
  localparam logic [7:0] dfu_req_getstatus = 8'h03;
  localparam logic [7:0] dfu_req_getstate  = 8'h05;
  localparam logic [7:0] dfu_req_abort     = 8'h06;

endpackage

//--- src/request_decoder.sv
`timescale 1ns/1ps
`include "usb_dfu_defines.svh"

module request_decoder (
  input  logic                     clk,
  input  logic                     reset,
  input  usb_ctrl_pkg::setup_pkt_u setup,
  input  logic                     setup_end,
  input  logic                     status_end,
  output logic [6:0]               dev_addr,
  resp_if.decoder                  resp
);
  import usb_ctrl_pkg::*;
  import dfu_pkg::*;

  localparam int aw = `DFU_FW_ADDR_W;

  resp_src_e   src_d;
  logic [aw-1:0] base_d;
  logic [7:0]  table_len;
  logic [7:0]  len_d;
  logic        stall_d;
  logic        set_addr_d;
  logic        block_load;
  dfu_state_e  state_d;
  logic [15:0] block_start; // w_value of the first upload
  logic [15:0] block_delta;
  logic [31:0] upload_ofs;
  logic        addr_pending;
  logic [6:0]  new_addr;

  assign block_delta = setup.fields.w_value - block_start;
  assign upload_ofs  = 32'(block_delta) * `USB_MAX_IN_PACKET % `DFU_FW_PAGE_SIZE;

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  always_comb begin
    src_d      = src_none;
    base_d     = '0;
    table_len  = 8'd0;
    stall_d    = 1'b0;
    set_addr_d = 1'b0;
    block_load = 1'b0;
    state_d    = resp.dfu_state;
    if (setup.fields.bm_request_type[6:5] == req_type_standard) begin
      case (setup.fields.b_request)
        req_get_descriptor: begin
          case (setup.fields.w_value[15:8])
            desc_type_device: begin
              src_d     = src_desc;
              base_d    = `DESC_DEVICE_OFS;
              table_len = `DESC_DEVICE_LEN;
            end
            desc_type_config: begin
              src_d     = src_desc;
              base_d    = `DESC_CONFIG_OFS;
              table_len = `DESC_CONFIG_LEN;
            end
            desc_type_string: begin
              if (setup.fields.w_value[7:0] == 8'd0) begin // language ids only
                src_d     = src_desc;
                base_d    = `DESC_LANGID_OFS;
                table_len = `DESC_LANGID_LEN;
              end
            end
            desc_type_qualifier: stall_d = 1'b1; // full speed only
            default: ;
          endcase
        end
        req_set_address: set_addr_d = 1'b1;
        req_set_configuration: src_d = src_none; // single config, nothing to do
        default: ;
      endcase
    end else if (setup.fields.bm_request_type[6:5] == req_type_class) begin
      case (setup.fields.b_request)
        dfu_req_upload: begin
          src_d     = src_firmware;
          table_len = 8'(`USB_MAX_IN_PACKET);
          if (resp.dfu_state == dfu_upload_idle) begin
            base_d = upload_ofs[aw-1:0];
          end else begin
            block_load = 1'b1; // first block starts the page
            state_d    = dfu_upload_idle;
          end
        end
        dfu_req_getstatus: begin
          src_d     = src_dfu_status;
          table_len = `DFU_STATUS_LEN;
        end
        dfu_req_getstate: begin
          src_d     = src_dfu_status;
          base_d    = `DFU_STATE_OFS;
          table_len = 8'd1;
        end
        dfu_req_abort: state_d = dfu_idle;
        default: ;
      endcase
    end
    len_d = (setup.fields.w_length < 16'(table_len)) ? setup.fields.w_length[7:0] : table_len;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp.src       <= src_none;
      resp.length    <= 8'd0;
      resp.stall_req <= 1'b0;
      resp.dfu_state <= dfu_idle;
      addr_pending   <= 1'b0;
      dev_addr       <= 7'd0;
    end else begin
      resp.stall_req <= setup_end && stall_d;
      if (setup_end) begin
        resp.src       <= src_d;
        resp.length    <= len_d;
        resp.dfu_state <= state_d;
        addr_pending   <= set_addr_d;
      end else if (status_end && addr_pending) begin
        dev_addr     <= new_addr; // status stage used the old address
        addr_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup_end) begin
      resp.base_addr <= base_d;
      if (set_addr_d) new_addr <= setup.fields.w_value[6:0];
      if (block_load) block_start <= setup.fields.w_value;
    end
  end

endmodule

//--- src/resp_if.sv
`timescale 1ns/1ps
`include "usb_dfu_defines.svh"

interface resp_if;
  import usb_ctrl_pkg::*;
  import dfu_pkg::*;

  resp_src_e                  src;
  logic [`DFU_FW_ADDR_W-1:0]  base_addr;
  logic [7:0]                 length;     // bytes to send, already clipped
  logic                       stall_req;
  logic [7:0]                 byte_index; // bytes already put
  dfu_state_e                 dfu_state;

  modport decoder (output src, base_addr, length, stall_req, dfu_state);

  modport stage (input length, stall_req, output byte_index);

  modport source (input src, base_addr, byte_index, dfu_state);

endinterface

//--- src/response_rom.sv
`timescale 1ns/1ps
`include "usb_dfu_defines.svh"

module response_rom (
  resp_if.source     resp,
  output logic [7:0] in_ep_data
);
  import usb_ctrl_pkg::*;
  import dfu_pkg::*;

  localparam int aw = `DFU_FW_ADDR_W;
  localparam int dw = $clog2(`DESC_TABLE_DEPTH);

  localparam logic [7:0] desc_table [`DESC_TABLE_DEPTH] = '{
    // device
    8'd18, 8'h01, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'(`USB_MAX_IN_PACKET),
    8'h09, 8'h12, 8'hb1, 8'h70, 8'h00, 8'h00, 8'h00, 8'h00,
    8'h00, 8'h01,
    // configuration, self powered
    8'd9, 8'h02, 8'(`DESC_CONFIG_LEN), 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'd50,
    // interface, application specific class, dfu mode
    8'd9, 8'h04, 8'h00, 8'h00, 8'h00, 8'hfe, 8'h01, 8'h02, 8'h00,
    // dfu functional, upload capable
    8'd9, 8'h21, 8'h02, 8'hff, 8'h00, 8'(`USB_MAX_IN_PACKET), 8'h00, 8'h1a, 8'h01,
    // string 0, us english
    8'd4, 8'h03, 8'h09, 8'h04,
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00
  };

  logic [aw-1:0] rd_addr;
  logic [7:0]    desc_byte;
  logic [7:0]    status_byte;
  logic [7:0]    fw_byte;

  assign rd_addr   = resp.base_addr + aw'(resp.byte_index);
  assign desc_byte = desc_table[rd_addr[dw-1:0]];
  assign fw_byte   = rd_addr[7:0]; // page pattern, byte equals its address

  always_comb begin
    case (rd_addr[2:0])
      3'd0:    status_byte = dfu_status_ok;
      3'd4:    status_byte = resp.dfu_state;
      default: status_byte = 8'h00; // poll timeout and istring
    endcase
  end

  always_comb begin
    case (resp.src)
      src_desc:       in_ep_data = desc_byte;
      src_dfu_status: in_ep_data = status_byte;
      src_firmware:   in_ep_data = fw_byte;
      default:        in_ep_data = 8'h00;
    endcase
  end

endmodule

//--- src/setup_capture.sv
`timescale 1ns/1ps

module setup_capture (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     out_ep_data_avail,
  input  logic                     out_ep_grant,
  input  logic                     out_ep_setup,
  input  logic [7:0]               out_ep_data,
  output logic                     setup_start,
  output logic                     pkt_end,
  output usb_ctrl_pkg::setup_pkt_u setup
);

  logic       avail_q;
  logic       data_valid;  // out_ep_data holds a byte this cycle
  logic       wr_en;
  logic [2:0] wr_idx;
  logic [2:0] wr_ptr;
  logic       ptr_full;    // all eight bytes written

  assign wr_en  = data_valid && out_ep_setup;
  assign wr_idx = setup_start ? 3'd0 : wr_ptr; // first byte comes with setup_start

  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q     <= 1'b0;
      data_valid  <= 1'b0;
      setup_start <= 1'b0;
      pkt_end     <= 1'b0;
    end else begin
      avail_q     <= out_ep_data_avail;
      data_valid  <= out_ep_data_avail && out_ep_grant;
      setup_start <= out_ep_data_avail && !avail_q && out_ep_setup;
      pkt_end     <= !out_ep_data_avail && avail_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= 3'd0;
      ptr_full <= 1'b0;
    end else if (wr_en) begin
      wr_ptr   <= wr_idx + 3'd1;
      ptr_full <= (wr_idx == 3'd7);
    end else if (setup_start) begin
      wr_ptr   <= 3'd0;
      ptr_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) setup.bytes[wr_idx] <= out_ep_data;
  end

  // a setup packet never carries a ninth byte
  a_no_wrap: assert property (@(posedge clk) disable iff (reset)
    wr_en && !setup_start |-> !ptr_full);

endmodule

//--- src/usb_ctrl_pkg.sv
package usb_ctrl_pkg;

  // wire order, first byte lands in the low bits
  typedef struct packed {
    logic [15:0] w_length;
    logic [15:0] w_index;
    logic [15:0] w_value;
    logic [7:0]  b_request;
    logic [7:0]  bm_request_type;
  } setup_fields_t;

  typedef union packed {
    logic [7:0][7:0] bytes;  // capture side
    setup_fields_t   fields; // decode side
  } setup_pkt_u;

  typedef enum logic [2:0] {
    stage_idle,
    stage_setup,
    stage_data_in,
    stage_data_out,
    stage_status_in,
    stage_status_out
  } ctrl_stage_e;

  typedef enum logic [1:0] {
    src_none,
    src_desc,
    src_dfu_status,
    src_firmware
  } resp_src_e;

  localparam logic [1:0] req_type_standard = 2'd0; // bm_request_type[6:5]
  localparam logic [1:0] req_type_class    = 2'd1;

  localparam logic [7:0] req_get_descriptor    = 8'h06;
  localparam logic [7:0] req_set_address       = 8'h05;
  localparam logic [7:0] req_set_configuration = 8'h09;

  localparam logic [7:0] desc_type_device    = 8'h01;
  localparam logic [7:0] desc_type_config    = 8'h02;
  localparam logic [7:0] desc_type_string    = 8'h03;
  localparam logic [7:0] desc_type_qualifier = 8'h06;

endpackage

//--- src/usb_dfu_ctrl_top.sv
`timescale 1ns/1ps

module usb_dfu_ctrl_top (
  input  logic       clk,
  input  logic       reset,
  output logic [6:0] dev_addr,

  // out endpoint
  output logic       out_ep_req,
  input  logic       out_ep_grant,
  input  logic       out_ep_data_avail,
  input  logic       out_ep_setup,
  output logic       out_ep_data_get,
  input  logic [7:0] out_ep_data,
  output logic       out_ep_stall,
  input  logic       out_ep_acked,

  // in endpoint
  output logic       in_ep_req,
  input  logic       in_ep_grant,
  input  logic       in_ep_data_free,
  output logic       in_ep_data_put,
  output logic [7:0] in_ep_data,
  output logic       in_ep_data_done,
  output logic       in_ep_stall,
  input  logic       in_ep_acked
);
  import usb_ctrl_pkg::*;

  setup_pkt_u setup;
  logic       setup_start;
  logic       pkt_end;
  logic       setup_end;
  logic       status_end;

  assign out_ep_req      = out_ep_data_avail; // take every out byte offered
  assign out_ep_data_get = out_ep_data_avail;
  assign out_ep_stall    = 1'b0;

  resp_if resp0 ();

  setup_capture capture0 (
    .clk, .reset, .out_ep_data_avail, .out_ep_grant, .out_ep_setup, .out_ep_data,
    .setup_start, .pkt_end, .setup
  );

  ctrl_xfer_fsm xfer_fsm0 (
    .clk, .reset, .setup_start, .pkt_end, .setup,
    .in_ep_grant, .in_ep_data_free, .in_ep_acked, .out_ep_acked,
    .in_ep_req, .in_ep_data_put, .in_ep_data_done, .in_ep_stall,
    .setup_end, .status_end, .resp(resp0.stage)
  );

  request_decoder decoder0 (
    .clk, .reset, .setup, .setup_end, .status_end, .dev_addr, .resp(resp0.decoder)
  );

  response_rom rom0 (
    .resp(resp0.source), .in_ep_data
  );

endmodule

//--- src/usb_dfu_defines.svh
`ifndef USB_DFU_DEFINES_SVH
`define USB_DFU_DEFINES_SVH

// endpoint 0 packet size, also the upload block size
`define USB_MAX_IN_PACKET 32

// firmware page seen by DFU_UPLOAD
`define DFU_FW_PAGE_SIZE 4096
`define DFU_FW_ADDR_W 12

// descriptor table layout
`define DESC_TABLE_DEPTH 64
`define DESC_DEVICE_OFS 'h00
`define DESC_CONFIG_OFS 'h12
`define DESC_LANGID_OFS 'h2D

`define DESC_DEVICE_LEN 18
`define DESC_CONFIG_LEN 27   // config + interface + dfu functional
`define DESC_LANGID_LEN 4

// GETSTATUS reply, GETSTATE reads only the state byte
`define DFU_STATUS_LEN 6
`define DFU_STATE_OFS 4

`endif

//--- tb.f
+incdir+src
src/usb_ctrl_pkg.sv
src/dfu_pkg.sv
src/resp_if.sv
src/setup_capture.sv
src/ctrl_xfer_fsm.sv
src/request_decoder.sv
src/response_rom.sv
src/usb_dfu_ctrl_top.sv
testbench/usb_host_model.sv
testbench/tb_usb_dfu_ctrl.sv

//--- testbench/tb_usb_dfu_ctrl.sv
`timescale 1ns/1ps

module tb_usb_dfu_ctrl;

  localparam int n_requests   = 14;
  localparam int reset_cycles = 16;
  localparam logic [7:0] state_dfu_idle    = 8'h02;
  localparam logic [7:0] state_upload_idle = 8'h09;

  logic       clk;
  logic       reset;
  logic [6:0] dev_addr;
  logic       out_ep_req, out_ep_grant, out_ep_data_avail, out_ep_setup;
  logic       out_ep_data_get, out_ep_stall, out_ep_acked;
  logic [7:0] out_ep_data;
  logic       in_ep_req, in_ep_grant, in_ep_data_free, in_ep_data_put;
  logic       in_ep_data_done, in_ep_stall, in_ep_acked;
  logic [7:0] in_ep_data;

  // expected response of the request in flight
  string      test_name;
  logic [7:0] exp_bytes [64];
  logic       exp_care [64];
  int         exp_len;
  logic       exp_stall;
  logic [6:0] exp_addr;
  logic       got_stall;
  int         rx_count;   // bytes the host collected
  logic       addr_chk;
  logic       stall_chk;
  int         put_count;
  int         errors;
  int         requests;

  usb_dfu_ctrl_top dut0 (.*);
  usb_host_model host0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always_ff @(posedge clk) begin
    if (reset || out_ep_setup) put_count <= 0;
    else if (in_ep_data_put && in_ep_grant) put_count <= put_count + 1;
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_byte_value: assert property (@(posedge clk) disable iff (reset)
    in_ep_data_put && in_ep_grant && put_count < exp_len && exp_care[put_count]
      |-> in_ep_data == exp_bytes[put_count])
    else begin
      errors++;
      $display("Error %s: byte %0d expected 0x%02h actual 0x%02h", test_name,
               $sampled(put_count), exp_bytes[$sampled(put_count)], $sampled(in_ep_data));
    end

  a_no_extra: assert property (@(posedge clk) disable iff (reset)
    in_ep_data_put && in_ep_grant |-> put_count < exp_len)
    else begin
      errors++;
      $display("%s: device put more than %0d bytes", test_name, exp_len);
    end

  // request drops once the last byte is counted
  a_req_left: assert property (@(posedge clk) disable iff (reset)
    in_ep_req |-> put_count < exp_len)
    else begin
      errors++;
      $display("%s: in_ep_req high with no bytes left to send", test_name);
    end

  a_done_count: assert property (@(posedge clk) disable iff (reset)
    in_ep_data_done |-> put_count == exp_len)
    else begin
      errors++;
      $display("Error %s: byte count expected %0d actual %0d", test_name, exp_len,
               $sampled(put_count));
    end

  a_rx_count: assert property (@(posedge clk) disable iff (reset)
    stall_chk |-> rx_count == exp_len)
    else begin
      errors++;
      $display("Error %s: bytes received expected %0d actual %0d", test_name, exp_len,
               rx_count);
    end

  // out side takes every byte offered
  a_out_follow: assert property (@(posedge clk) disable iff (reset)
    out_ep_req == out_ep_data_avail && out_ep_data_get == out_ep_data_avail)
    else begin
      errors++;
      $display("Error %s: out_ep_req/get expected %0b actual %0b/%0b", test_name,
               $sampled(out_ep_data_avail), $sampled(out_ep_req),
               $sampled(out_ep_data_get));
    end

  a_out_no_stall: assert property (@(posedge clk) disable iff (reset)
    !out_ep_stall)
    else begin
      errors++;
      $display("%s: OUT endpoint stalled", test_name);
    end

  a_stall_only: assert property (@(posedge clk) disable iff (reset)
    in_ep_stall |-> exp_stall)
    else begin
      errors++;
      $display("%s: IN endpoint stalled on a valid request", test_name);
    end

  a_no_put_stall: assert property (@(posedge clk) disable iff (reset)
    exp_stall |-> !in_ep_data_put)
    else begin
      errors++;
      $display("%s: data put during a stalled request", test_name);
    end

  a_stall_seen: assert property (@(posedge clk) disable iff (reset)
    stall_chk |-> got_stall == exp_stall)
    else begin
      errors++;
      $display("Error %s: stall expected %0b actual %0b", test_name, exp_stall, got_stall);
    end

  // new address only after the host acked the status stage
  a_addr_late: assert property (@(posedge clk) disable iff (reset)
    dev_addr != $past(dev_addr) |-> $past(in_ep_acked))
    else begin
      errors++;
      $display("%s: address changed before the status stage was acked", test_name);
    end

  a_addr_value: assert property (@(posedge clk) disable iff (reset)
    addr_chk |-> dev_addr == exp_addr)
    else begin
      errors++;
      $display("Error %s: dev_addr expected 0x%02h actual 0x%02h", test_name, exp_addr,
               $sampled(dev_addr));
    end

  //////////////////////////////////////////////////
  // sequence helpers
  //////////////////////////////////////////////////

  task automatic clear_expect(input int len);
    int i;
    exp_len = len;
    for (i = 0; i < 64; i++) begin
      exp_care[i]  = 1'b0;
      exp_bytes[i] = 8'h00;
    end
  endtask

  task automatic expect_byte(input int idx, input logic [7:0] value);
    exp_care[idx]  = 1'b1;
    exp_bytes[idx] = value;
  endtask

  // firmware page, byte equals low bits of its address
  task automatic expect_ramp(input int start);
    int i;
    clear_expect(32);
    for (i = 0; i < 32; i++) expect_byte(i, 8'(start + i));
  endtask

  task automatic expect_status(input logic [7:0] state);
    int i;
    clear_expect(6);
    for (i = 0; i < 6; i++) expect_byte(i, (i == 4) ? state : 8'h00);
  endtask

  task automatic expect_device(input int len);
    clear_expect(len);
    expect_byte(0, 8'd18);
    expect_byte(1, 8'h01);
    expect_byte(7, 8'd32);   // bMaxPacketSize0
  endtask

  task automatic run_request(input string name, input logic [7:0] req_type,
                             input logic [7:0] request, input logic [15:0] value,
                             input logic [15:0] index, input logic [15:0] length);
    logic stalled;
    int   n_bytes;
    test_name = name;
    requests++;
    host0.send_setup(req_type, request, value, index, length);
    host0.collect_in(stalled, n_bytes);
    got_stall = stalled;
    rx_count  = n_bytes;
    if (!stalled && req_type[7] && length != 16'd0) host0.ack_out_status();
    @(posedge clk);
    stall_chk <= 1'b1;
    @(posedge clk);
    stall_chk <= 1'b0;
    @(posedge clk);
  endtask

  task automatic check_address();
    @(posedge clk);
    addr_chk <= 1'b1;
    @(posedge clk);
    addr_chk <= 1'b0;
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // watchdog and test sequence
  //////////////////////////////////////////////////

  initial begin
    repeat (n_requests * 200 + reset_cycles) @(posedge clk);
    $display("watchdog expired, a transfer never finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    reset     = 1'b1;
    errors    = 0;
    requests  = 0;
    test_name = "reset";
    exp_stall = 1'b0;
    exp_addr  = 7'd0;
    got_stall = 1'b0;
    rx_count  = 0;
    addr_chk  = 1'b0;
    stall_chk = 1'b0;
    clear_expect(0);
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    expect_device(18);
    run_request("device descriptor", 8'h80, 8'h06, 16'h0100, 16'h0000, 16'd64);
    expect_device(8);
    run_request("device descriptor short", 8'h80, 8'h06, 16'h0100, 16'h0000, 16'd8);

    clear_expect(27);
    expect_byte(0, 8'd9);
    expect_byte(1, 8'h02);
    expect_byte(2, 8'd27);    // wTotalLength low byte
    run_request("config descriptor", 8'h80, 8'h06, 16'h0200, 16'h0000, 16'd255);
    clear_expect(4);
    expect_byte(0, 8'd4);
    expect_byte(1, 8'h03);
    expect_byte(2, 8'h09);
    expect_byte(3, 8'h04);
    run_request("language id", 8'h80, 8'h06, 16'h0300, 16'h0000, 16'd255);

    test_name = "address before";
    check_address();
    clear_expect(0);
    run_request("set address", 8'h00, 8'h05, 16'h002A, 16'h0000, 16'd0);
    exp_addr = 7'h2A;
    check_address();

    clear_expect(1);
    expect_byte(0, state_dfu_idle);
    run_request("getstate after reset", 8'hA1, 8'h05, 16'h0000, 16'h0000, 16'd1);
    expect_status(state_dfu_idle);
    run_request("getstatus", 8'hA1, 8'h03, 16'h0000, 16'h0000, 16'd6);

    expect_ramp(0);
    run_request("upload block 5", 8'hA1, 8'h02, 16'd5, 16'h0000, 16'd32);
    expect_ramp(32);
    run_request("upload block 6", 8'hA1, 8'h02, 16'd6, 16'h0000, 16'd32);
    clear_expect(1);
    expect_byte(0, state_upload_idle);
    run_request("getstate in upload", 8'hA1, 8'h05, 16'h0000, 16'h0000, 16'd1);
    clear_expect(0);
    run_request("abort", 8'h21, 8'h06, 16'h0000, 16'h0000, 16'd0);
    clear_expect(1);
    expect_byte(0, state_dfu_idle);
    run_request("getstate after abort", 8'hA1, 8'h05, 16'h0000, 16'h0000, 16'd1);

    clear_expect(0);
    exp_stall = 1'b1;  // full speed device has no qualifier
    run_request("device qualifier", 8'h80, 8'h06, 16'h0600, 16'h0000, 16'd10);
    exp_stall = 1'b0;
    expect_device(18);
    run_request("device after stall", 8'h80, 8'h06, 16'h0100, 16'h0000, 16'd64);

    repeat (4) @(posedge clk);
    $display("requests run: %0d, errors: %0d", requests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/usb_host_model.sv
`timescale 1ns/1ps

module usb_host_model (
  input  logic       clk,
  // out endpoint, host to device
  output logic       out_ep_grant,
  output logic       out_ep_data_avail,
  output logic       out_ep_setup,
  output logic [7:0] out_ep_data,
  output logic       out_ep_acked,
  // in endpoint, device to host
  output logic       in_ep_grant,
  output logic       in_ep_data_free,
  output logic       in_ep_acked,
  input  logic       in_ep_data_put,
  input  logic [7:0] in_ep_data,
  input  logic       in_ep_data_done,
  input  logic       in_ep_stall
);

  logic [7:0]  rx_q [$];  // bytes of the last IN data stage
  logic [31:0] rng_state;

  initial begin
    out_ep_grant      = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = 8'h00;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b1;
    in_ep_data_free   = 1'b1;
    in_ep_acked       = 1'b0;
    rng_state         = 32'd98207;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // eight bytes, each on the bus one cycle after its grant
  task automatic send_setup(input logic [7:0] req_type, input logic [7:0] request,
                            input logic [15:0] value, input logic [15:0] index,
                            input logic [15:0] length);
    logic [7:0] pkt [8];
    int         i;
    pkt[0] = req_type;
    pkt[1] = request;
    pkt[2] = value[7:0];
    pkt[3] = value[15:8];
    pkt[4] = index[7:0];
    pkt[5] = index[15:8];
    pkt[6] = length[7:0];
    pkt[7] = length[15:8];
    for (i = 0; i <= 8; i++) begin
      @(posedge clk);
      out_ep_setup      <= 1'b1;
      out_ep_data_avail <= (i < 8);
      out_ep_grant      <= (i < 8);
      if (i > 0) out_ep_data <= pkt[i-1];
    end
    @(posedge clk);
    out_ep_setup <= 1'b0;
    out_ep_data  <= 8'h00;
  endtask

  // also catches the zero length done of a request without data
  task automatic collect_in(output logic stalled, output int n_bytes);
    logic finished;
    rx_q.delete();
    stalled  = 1'b0;
    finished = 1'b0;
    while (!finished) begin
      @(posedge clk);
      if (in_ep_data_put && in_ep_grant) rx_q.push_back(in_ep_data);
      if (in_ep_data_done) begin
        finished = 1'b1;
      end else if (in_ep_stall) begin
        stalled  = 1'b1;
        finished = 1'b1;
      end
      rng_state = lcg_next(rng_state);
      in_ep_data_free <= |rng_state[17:16];  // low about one cycle in four
      in_ep_grant     <= |rng_state[19:18];
    end
    if (!stalled) begin
      in_ep_acked <= 1'b1;
      @(posedge clk);
      in_ep_acked <= 1'b0;
    end
    in_ep_data_free <= 1'b1;
    in_ep_grant     <= 1'b1;
    n_bytes = rx_q.size();
  endtask

  task automatic ack_out_status();
    @(posedge clk);
    out_ep_acked <= 1'b1;
    @(posedge clk);
    out_ep_acked <= 1'b0;
  endtask

endmodule
